//--- testbench/encrypt_stim.txt
// per record: h s cw (hex, 67 bits), then locations r1[0..2] r2[0..2] e[0..2] (hex)
// records 2 to 4 repeat a location in r1, e and r2
4F3A9C215D7E08B61 2B7E151628AED2A6A 13198A2E03707344A 05 21 3A 00 17 42 0C 30 41
7FFFFFFFFFFFFFFFF 00000000000000001 00000000000000000 10 10 22 01 02 03 00 01 02
10000000000000000 55555555555555555 2AAAAAAAAAAAAAAAA 00 20 40 3F 05 11 42 07 42
0123456789ABCDEF0 6E5D4C3B2A1908F7E 0F0F0F0F0F0F0F0F0 01 02 03 2A 2A 13 04 05 06
40000000000000001 7F0000000000000FF 3C3C3C3C3C3C3C3C3 42 00 41 42 41 01 00 42 21
1D2C3B4A596877865 0A1B2C3D4E5F60718 77777777777777777 33 0B 1F 09 3C 27 18 2D 40

//--- verilog.f
hdl/hqc_pkg.sv
hdl/word_mem.sv
hdl/sparse_vector_bank.sv
hdl/sparse_dense_mult.sv
hdl/loc_based_adder.sv
hdl/ciphertext_buffer.sv
hdl/encrypt_ctrl.sv
hdl/hqc_encrypt.sv
testbench/encrypt_properties.sv
testbench/encrypt_checker.sv
testbench/tb_encrypt.sv

//--- testbench/tb_encrypt.sv
`timescale 1ns/1ps

module tb_encrypt;

    import hqc_pkg::*;

    localparam int NUM_REC = 6;
    localparam int REC_WORDS = 3 + 3 * WEIGHT;
    localparam int DONE_TIMEOUT = 200;
    localparam int EXTRA_START_REC = 2;

    logic clk;
    logic rst;
    logic start;
    loc_wr_t loc_wr;
    poly_t h;
    poly_t s;
    poly_t cw;
    ct_rd_t rd;
    logic done;
    word_t rd_data;

    // one token per entry and 12 entries per record
    logic [N:0] stim_mem [NUM_REC * REC_WORDS];
    int timeout_errors;
    int err_count;
    int run_count;
    int check_count;
    int total_errors;

    hqc_encrypt i_dut (
        .clk     (clk),
        .rst     (rst),
        .start   (start),
        .loc_wr  (loc_wr),
        .h       (h),
        .s       (s),
        .cw      (cw),
        .rd      (rd),
        .done    (done),
        .rd_data (rd_data)
    );

    encrypt_checker i_checker (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .done        (done),
        .loc_wr      (loc_wr),
        .h           (h),
        .s           (s),
        .cw          (cw),
        .rd          (rd),
        .rd_data     (rd_data),
        .err_count   (err_count),
        .run_count   (run_count),
        .check_count (check_count)
    );

    bind hqc_encrypt encrypt_properties i_props (
        .clk   (clk),
        .rst   (rst),
        .start (start),
        .done  (done),
        .ct_wr (ct_wr)
    );

    always #20 clk = ~clk;

    // r1, r2 and e in file order
    task automatic load_locations(int base);
        for (int v = 0; v < 3; v++) begin
            for (int i = 0; i < WEIGHT; i++) begin
                @(posedge clk);
                loc_wr <= '{en: 1'b1, vec: vec_sel_t'(v), idx: IDX_W'(i),
                            loc: loc_t'(stim_mem[base + 3 + v * WEIGHT + i])};
            end
        end
        @(posedge clk);
        loc_wr.en <= 1'b0;
    endtask

    task automatic wait_for_done();
        int cycles;
        cycles = 0;
        while (done !== 1'b1 && cycles < DONE_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (done !== 1'b1) begin
            $display("timeout: no done within %0d cycles at %0t", DONE_TIMEOUT, $time);
            timeout_errors++;
        end
    endtask

    task automatic read_results();
        for (int v = 0; v < 2; v++) begin
            for (int w = 0; w < OUT_DEPTH; w++) begin
                @(posedge clk);
                rd <= '{en: 1'b1, is_v: v[0], addr: WADDR_W'(w)};
            end
        end
        @(posedge clk);
        rd.en <= 1'b0;
    endtask

    task automatic run_record(int rec);
        int base;
        base = rec * REC_WORDS;
        load_locations(base);
        @(posedge clk);
        h <= stim_mem[base][N-1:0];
        s <= stim_mem[base + 1][N-1:0];
        cw <= stim_mem[base + 2][N-1:0];
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        // a second start while the run is busy
        if (rec == EXTRA_START_REC) begin
            repeat (3) @(posedge clk);
            start <= 1'b1;
            @(posedge clk);
            start <= 1'b0;
        end
        wait_for_done();
        read_results();
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        start = 1'b0;
        loc_wr = '0;
        h = '0;
        s = '0;
        cw = '0;
        rd = '0;
        timeout_errors = 0;
        $readmemh("testbench/encrypt_stim.txt", stim_mem);
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        for (int rec = 0; rec < NUM_REC; rec++) begin
            run_record(rec);
        end
        // leave room for any stray done
        repeat (40) @(posedge clk);
        total_errors = err_count + timeout_errors;
        if (run_count != NUM_REC) begin
            $display("expected %0d done pulses but saw %0d", NUM_REC, run_count);
            total_errors++;
        end
        $display("words checked %0d, mismatches %0d, timeouts %0d, total errors %0d",
                 check_count, err_count, timeout_errors, total_errors);
        if (total_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- testbench/encrypt_checker.sv
`timescale 1ns/1ps

module encrypt_checker (
    input  logic            clk,
    input  logic            rst,
    input  logic            start,
    input  logic            done,
    input  hqc_pkg::loc_wr_t loc_wr,
    input  hqc_pkg::poly_t  h,
    input  hqc_pkg::poly_t  s,
    input  hqc_pkg::poly_t  cw,
    input  hqc_pkg::ct_rd_t rd,
    input  hqc_pkg::word_t  rd_data,
    output int              err_count,
    output int              run_count,
    output int              check_count
);

    import hqc_pkg::*;

    loc_t r1_tab [WEIGHT];
    loc_t r2_tab [WEIGHT];
    loc_t e_tab [WEIGHT];
    logic [PAD_W-1:0] exp_u;
    logic [PAD_W-1:0] exp_v;
    logic active;
    logic rd_pend;
    logic rd_pend_v;
    logic [WADDR_W-1:0] rd_pend_addr;

    // dense times sparse, one shifted copy per location
    function automatic poly_t times_sparse(poly_t dense, loc_t locs [WEIGHT]);
        poly_t acc;
        acc = '0;
        for (int k = 0; k < WEIGHT; k++) begin
            for (int i = 0; i < N; i++) begin
                if (dense[i]) begin
                    acc[(i + int'(locs[k])) % N] ^= 1'b1;
                end
            end
        end
        return acc;
    endfunction

    // sparse plus dense, each location toggles one bit
    function automatic poly_t plus_sparse(poly_t base, loc_t locs [WEIGHT]);
        poly_t acc;
        acc = base;
        for (int k = 0; k < WEIGHT; k++) begin
            acc[int'(locs[k]) % N] ^= 1'b1;
        end
        return acc;
    endfunction

    initial begin
        err_count = 0;
        run_count = 0;
        check_count = 0;
        active = 1'b0;
        rd_pend = 1'b0;
    end

    always @(posedge clk) begin
        word_t expected;
        if (rst) begin
            active = 1'b0;
            rd_pend = 1'b0;
            if (done === 1'b1) begin
                $display("done was high during reset at %0t", $time);
                err_count++;
            end
        end else begin
            // shadow copy of the location memories
            if (loc_wr.en && loc_wr.idx < WEIGHT) begin
                case (loc_wr.vec)
                    VEC_R1: r1_tab[loc_wr.idx] = loc_wr.loc;
                    VEC_R2: r2_tab[loc_wr.idx] = loc_wr.loc;
                    default: e_tab[loc_wr.idx] = loc_wr.loc;
                endcase
            end
            // read data shows up one cycle after the request
            if (rd_pend) begin
                if (rd_pend_v) begin
                    expected = exp_v[rd_pend_addr * WORD_W +: WORD_W];
                end else begin
                    expected = exp_u[rd_pend_addr * WORD_W +: WORD_W];
                end
                check_count++;
                if (rd_data !== expected) begin
                    $display("ERR t=%0t rd_data (%s word %0d) expected %h actual %h",
                             $time, rd_pend_v ? "v" : "u", rd_pend_addr, expected, rd_data);
                    err_count++;
                end
            end
            rd_pend = rd.en;
            rd_pend_v = rd.is_v;
            rd_pend_addr = rd.addr;
            if (done === 1'b1) begin
                if (!active) begin
                    $display("done pulsed at %0t with no run in progress", $time);
                    err_count++;
                end
                active = 1'b0;
                run_count++;
            end
            // start inside a run is ignored by the DUT
            if (start && !active) begin
                active = 1'b1;
                exp_u = '0;
                exp_v = '0;
                exp_u[N-1:0] = plus_sparse(times_sparse(h, r2_tab), r1_tab);
                exp_v[N-1:0] = cw ^ plus_sparse(times_sparse(s, r2_tab), e_tab);
            end
        end
    end

endmodule

//--- testbench/encrypt_properties.sv
`timescale 1ns/1ps

module encrypt_properties (
    input logic            clk,
    input logic            rst,
    input logic            start,
    input logic            done,
    input hqc_pkg::ct_wr_t ct_wr
);

    logic run_active;

    // a start seen in the done cycle is taken, the FSM is already idle
    always_ff @(posedge clk) begin
        if (rst) begin
            run_active <= 1'b0;
        end else if (start && (!run_active || done)) begin
            run_active <= 1'b1;
        end else if (done) begin
            run_active <= 1'b0;
        end
    end

    a_done_one_cycle: assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else $error("done stayed high for more than one cycle");

    a_done_in_run: assert property (@(posedge clk) disable iff (rst) done |-> run_active)
        else $error("done pulsed while no run was active");

    a_wr_in_run: assert property (@(posedge clk) disable iff (rst)
        $rose(ct_wr.en) |-> run_active)
        else $error("result write started outside a run");

    a_reset_quiet: assert property (@(posedge clk) rst |=> (!done && !ct_wr.en))
        else $error("done or result write active right after reset");

endmodule

//--- hdl/hqc_encrypt.sv
`timescale 1ns/1ps

module hqc_encrypt (
    input  logic             clk,
    input  logic             rst,
    input  logic             start,
    input  hqc_pkg::loc_wr_t loc_wr,
    input  hqc_pkg::poly_t   h,
    input  hqc_pkg::poly_t   s,
    input  hqc_pkg::poly_t   cw,
    input  hqc_pkg::ct_rd_t  rd,
    output logic             done,
    output hqc_pkg::word_t   rd_data
);

    import hqc_pkg::*;

    logic mult_start;
    logic mult_use_s;
    logic mult_done;
    logic add_start;
    logic add_done;
    vec_sel_t add_vec;
    logic [IDX_W-1:0] mult_loc_addr;
    logic [IDX_W-1:0] add_loc_addr;
    loc_t mult_loc;
    loc_t add_loc;
    poly_t prod;
    poly_t sum;
    poly_t add_base;
    ct_wr_t ct_wr;

    sparse_vector_bank i_bank (
        .clk    (clk),
        .loc_wr (loc_wr),
        .a_addr (mult_loc_addr),
        .a_loc  (mult_loc),
        .b_addr (add_loc_addr),
        .b_vec  (add_vec),
        .b_loc  (add_loc)
    );

    sparse_dense_mult i_mult (
        .clk      (clk),
        .rst      (rst),
        .start    (mult_start),
        .use_s    (mult_use_s),
        .h        (h),
        .s        (s),
        .loc_addr (mult_loc_addr),
        .loc      (mult_loc),
        .done     (mult_done),
        .prod     (prod)
    );

    loc_based_adder i_adder (
        .clk      (clk),
        .rst      (rst),
        .start    (add_start),
        .base     (add_base),
        .loc_addr (add_loc_addr),
        .loc      (add_loc),
        .done     (add_done),
        .sum      (sum)
    );

    ciphertext_buffer i_ctbuf (
        .clk     (clk),
        .ct_wr   (ct_wr),
        .rd      (rd),
        .rd_data (rd_data)
    );

    encrypt_ctrl i_ctrl (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .done       (done),
        .mult_start (mult_start),
        .mult_use_s (mult_use_s),
        .mult_done  (mult_done),
        .prod       (prod),
        .add_start  (add_start),
        .add_vec    (add_vec),
        .add_base   (add_base),
        .add_done   (add_done),
        .sum        (sum),
        .cw         (cw),
        .ct_wr      (ct_wr)
    );

endmodule

//--- hdl/encrypt_ctrl.sv
`timescale 1ns/1ps

module encrypt_ctrl (
    input  logic              clk,
    input  logic              rst,
    input  logic              start,
    output logic              done,
    output logic              mult_start,
    output logic              mult_use_s,
    input  logic              mult_done,
    input  hqc_pkg::poly_t    prod,
    output logic              add_start,
    output hqc_pkg::vec_sel_t add_vec,
    output hqc_pkg::poly_t    add_base,
    input  logic              add_done,
    input  hqc_pkg::poly_t    sum,
    input  hqc_pkg::poly_t    cw,
    output hqc_pkg::ct_wr_t   ct_wr
);

    import hqc_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE   = 3'd0,
        ST_MULT_H = 3'd1,
        ST_ADD_R1 = 3'd2,
        ST_COPY_U = 3'd3,
        ST_MULT_S = 3'd4,
        ST_ADD_E  = 3'd5,
        ST_COPY_V = 3'd6
    } state_t;

    state_t state;
    logic [WADDR_W-1:0] word;
    poly_t copy_src;
    logic [PAD_W-1:0] copy_pad;

    // adder always starts from the latest product
    assign add_base = prod;

    // codeword folded in on the v copy only
    assign copy_src = (state == ST_COPY_V) ? (sum ^ cw) : sum;
    assign copy_pad = {{(PAD_W - N){1'b0}}, copy_src};

    always_comb begin
        ct_wr.en   = (state == ST_COPY_U) || (state == ST_COPY_V);
        ct_wr.is_v = (state == ST_COPY_V);
        ct_wr.addr = word;
        ct_wr.data = copy_pad[word * WORD_W +: WORD_W];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= ST_IDLE;
            word       <= '0;
            mult_start <= 1'b0;
            mult_use_s <= 1'b0;
            add_start  <= 1'b0;
            add_vec    <= VEC_R1;
            done       <= 1'b0;
        end else begin
            // start and done strobes last one cycle
            mult_start <= 1'b0;
            add_start  <= 1'b0;
            done       <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        mult_start <= 1'b1;
                        mult_use_s <= 1'b0;
                        state      <= ST_MULT_H;
                    end
                end
                ST_MULT_H: begin
                    if (mult_done) begin
                        add_start <= 1'b1;
                        add_vec   <= VEC_R1;
                        state     <= ST_ADD_R1;
                    end
                end
                ST_ADD_R1: begin
                    if (add_done) begin
                        state <= ST_COPY_U;
                    end
                end
                ST_COPY_U: begin
                    if (word == WADDR_W'(OUT_DEPTH - 1)) begin
                        word       <= '0;
                        mult_start <= 1'b1;
                        mult_use_s <= 1'b1;
                        state      <= ST_MULT_S;
                    end else begin
                        word <= word + 1'b1;
                    end
                end
                ST_MULT_S: begin
                    if (mult_done) begin
                        add_start <= 1'b1;
                        add_vec   <= VEC_E;
                        state     <= ST_ADD_E;
                    end
                end
                ST_ADD_E: begin
                    if (add_done) begin
                        state <= ST_COPY_V;
                    end
                end
                ST_COPY_V: begin
                    if (word == WADDR_W'(OUT_DEPTH - 1)) begin
                        word  <= '0;
                        done  <= 1'b1;
                        state <= ST_IDLE;
                    end else begin
                        word <= word + 1'b1;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

//--- hdl/ciphertext_buffer.sv
`timescale 1ns/1ps

module ciphertext_buffer (
    input  logic            clk,
    input  hqc_pkg::ct_wr_t ct_wr,
    input  hqc_pkg::ct_rd_t rd,
    output hqc_pkg::word_t  rd_data
);

    import hqc_pkg::*;

    logic u_we;
    logic v_we;
    logic [WADDR_W-1:0] u_addr;
    logic [WADDR_W-1:0] v_addr;
    word_t u_q;
    word_t v_q;
    logic rd_is_v_q;

    assign u_we = ct_wr.en && !ct_wr.is_v;
    assign v_we = ct_wr.en && ct_wr.is_v;

    // writes only happen during a run, reads only outside one
    assign u_addr = u_we ? ct_wr.addr : rd.addr;
    assign v_addr = v_we ? ct_wr.addr : rd.addr;

    word_mem #(.T(word_t), .DEPTH(OUT_DEPTH)) i_u_mem (
        .clk   (clk),
        .we    (u_we),
        .addr  (u_addr),
        .wdata (ct_wr.data),
        .rdata (u_q)
    );

    word_mem #(.T(word_t), .DEPTH(OUT_DEPTH)) i_v_mem (
        .clk   (clk),
        .we    (v_we),
        .addr  (v_addr),
        .wdata (ct_wr.data),
        .rdata (v_q)
    );

    // u/v select lines up with the registered read
    always_ff @(posedge clk) begin
        if (rd.en) begin
            rd_is_v_q <= rd.is_v;
        end
    end

    assign rd_data = rd_is_v_q ? v_q : u_q;

endmodule

//--- hdl/loc_based_adder.sv
`timescale 1ns/1ps

module loc_based_adder (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      start,
    input  hqc_pkg::poly_t            base,
    output logic [hqc_pkg::IDX_W-1:0] loc_addr,
    input  hqc_pkg::loc_t             loc,
    output logic                      done,
    output hqc_pkg::poly_t            sum
);

    import hqc_pkg::*;

    logic issuing;
    logic loc_vld;
    logic loc_last;

    // one-hot of the location, reduced mod N
    function automatic poly_t loc_bit(loc_t l);
        int unsigned pos;
        pos = (l >= N) ? (l - N) : l;
        return poly_t'(1) << pos;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            issuing  <= 1'b0;
            loc_addr <= '0;
            loc_vld  <= 1'b0;
            loc_last <= 1'b0;
            done     <= 1'b0;
        end else begin
            loc_vld  <= issuing;
            loc_last <= issuing && (loc_addr == IDX_W'(WEIGHT - 1));
            done     <= loc_vld && loc_last;
            if (start) begin
                issuing  <= 1'b1;
                loc_addr <= '0;
            end else if (issuing) begin
                if (loc_addr == IDX_W'(WEIGHT - 1)) begin
                    issuing <= 1'b0;
                end else begin
                    loc_addr <= loc_addr + 1'b1;
                end
            end
        end
    end

    // a location seen twice flips back
    always_ff @(posedge clk) begin
        if (start) begin
            sum <= base;
        end else if (loc_vld) begin
            sum <= sum ^ loc_bit(loc);
        end
    end

endmodule

//--- hdl/sparse_dense_mult.sv
`timescale 1ns/1ps

module sparse_dense_mult (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      start,
    input  logic                      use_s,
    input  hqc_pkg::poly_t            h,
    input  hqc_pkg::poly_t            s,
    output logic [hqc_pkg::IDX_W-1:0] loc_addr,
    input  hqc_pkg::loc_t             loc,
    output logic                      done,
    output hqc_pkg::poly_t            prod
);

    import hqc_pkg::*;

    logic issuing;
    logic loc_vld;
    logic loc_last;
    poly_t operand;

    // multiply by x^loc, wrapping at x^N
    function automatic poly_t rotate_up(poly_t p, loc_t l);
        logic [2*N-1:0] twice;
        int unsigned sh;
        sh = (l >= N) ? (l - N) : l;
        twice = {p, p} << sh;
        return twice[2*N-1:N];
    endfunction

    assign operand = use_s ? s : h;

    // address leads the returned location by one cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            issuing  <= 1'b0;
            loc_addr <= '0;
            loc_vld  <= 1'b0;
            loc_last <= 1'b0;
            done     <= 1'b0;
        end else begin
            loc_vld  <= issuing;
            loc_last <= issuing && (loc_addr == IDX_W'(WEIGHT - 1));
            done     <= loc_vld && loc_last;
            if (start) begin
                issuing  <= 1'b1;
                loc_addr <= '0;
            end else if (issuing) begin
                if (loc_addr == IDX_W'(WEIGHT - 1)) begin
                    issuing <= 1'b0;
                end else begin
                    loc_addr <= loc_addr + 1'b1;
                end
            end
        end
    end

    // accumulator, held after the last location
    always_ff @(posedge clk) begin
        if (start) begin
            prod <= '0;
        end else if (loc_vld) begin
            prod <= prod ^ rotate_up(operand, loc);
        end
    end

endmodule

//--- hdl/sparse_vector_bank.sv
`timescale 1ns/1ps

module sparse_vector_bank (
    input  logic                      clk,
    input  hqc_pkg::loc_wr_t          loc_wr,
    input  logic [hqc_pkg::IDX_W-1:0] a_addr,
    output hqc_pkg::loc_t             a_loc,
    input  logic [hqc_pkg::IDX_W-1:0] b_addr,
    input  hqc_pkg::vec_sel_t         b_vec,
    output hqc_pkg::loc_t             b_loc
);

    import hqc_pkg::*;

    logic we_r1;
    logic we_r2;
    logic we_e;
    logic [IDX_W-1:0] addr_r1;
    logic [IDX_W-1:0] addr_r2;
    logic [IDX_W-1:0] addr_e;
    loc_t r1_q;
    loc_t e_q;
    vec_sel_t b_vec_q;

    assign we_r1 = loc_wr.en && (loc_wr.vec == VEC_R1);
    assign we_r2 = loc_wr.en && (loc_wr.vec == VEC_R2);
    assign we_e  = loc_wr.en && (loc_wr.vec == VEC_E);

    // load address wins, otherwise the engines read
    assign addr_r1 = we_r1 ? loc_wr.idx : b_addr;
    assign addr_r2 = we_r2 ? loc_wr.idx : a_addr;
    assign addr_e  = we_e  ? loc_wr.idx : b_addr;

    word_mem #(.T(loc_t), .DEPTH(WEIGHT)) i_r1_mem (
        .clk   (clk),
        .we    (we_r1),
        .addr  (addr_r1),
        .wdata (loc_wr.loc),
        .rdata (r1_q)
    );

    // port a is dedicated to r2
    word_mem #(.T(loc_t), .DEPTH(WEIGHT)) i_r2_mem (
        .clk   (clk),
        .we    (we_r2),
        .addr  (addr_r2),
        .wdata (loc_wr.loc),
        .rdata (a_loc)
    );

    word_mem #(.T(loc_t), .DEPTH(WEIGHT)) i_e_mem (
        .clk   (clk),
        .we    (we_e),
        .addr  (addr_e),
        .wdata (loc_wr.loc),
        .rdata (e_q)
    );

    // select follows the read data by one cycle
    always_ff @(posedge clk) begin
        b_vec_q <= b_vec;
    end

    assign b_loc = (b_vec_q == VEC_E) ? e_q : r1_q;

endmodule

//--- hdl/word_mem.sv
`timescale 1ns/1ps

module word_mem #(
    parameter type T = logic,
    parameter int DEPTH = 2
) (
    input  logic                                       clk,
    input  logic                                       we,
    input  logic [((DEPTH > 1) ? $clog2(DEPTH) : 1)-1:0] addr,
    input  T                                           wdata,
    output T                                           rdata
);

    T mem [DEPTH];

    // single port, registered read of the old contents
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];
    end

endmodule

//--- hdl/hqc_pkg.sv
package hqc_pkg;

    // toy ring GF(2)[x]/(x^N - 1)
    localparam int N = 67;
    localparam int WEIGHT = 3;
    localparam int LOC_W = 7;
    localparam int IDX_W = 2;

    // readout geometry, u and v are padded to OUT_DEPTH words
    localparam int WORD_W = 16;
    localparam int OUT_DEPTH = 5;
    localparam int WADDR_W = 3;
    localparam int PAD_W = WORD_W * OUT_DEPTH;

    typedef logic [N-1:0] poly_t;
    typedef logic [LOC_W-1:0] loc_t;
    typedef logic [WORD_W-1:0] word_t;

    // which sparse vector a location belongs to
    typedef enum logic [1:0] {
        VEC_R1 = 2'd0,
        VEC_R2 = 2'd1,
        VEC_E  = 2'd2
    } vec_sel_t;

    // location load port
    typedef struct packed {
        logic             en;
        vec_sel_t         vec;
        logic [IDX_W-1:0] idx;
        loc_t             loc;
    } loc_wr_t;

    // word write into the u/v result memories
    typedef struct packed {
        logic               en;
        logic               is_v;
        logic [WADDR_W-1:0] addr;
        word_t              data;
    } ct_wr_t;

    // word readout request
    typedef struct packed {
        logic               en;
        logic               is_v;
        logic [WADDR_W-1:0] addr;
    } ct_rd_t;

endpackage
